//--- Makefile
# Verilator build and run of the front end testbench.
BIN = obj_dir/Vtb_front_end

.PHONY: run clean

run: $(BIN)
	./$(BIN) | tee sim.log
	grep -q "^Testbench passed$$" sim.log

# Rebuilt only when a source, the macro header or the file list changes.
$(BIN): tb.f hw/fe_macros.svh $(shell grep -v '^+' tb.f)
	verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_front_end -o Vtb_front_end

clean:
	rm -rf obj_dir sim.log

//--- bench/axi_mem_model.sv
// Read-only memory that answers single-beat AXI reads in order.
// Only address bits 10 to 3 select a word, so the 2 KiB image repeats.
// rresp is always OKAY and every beat is the last one of its read.
`timescale 1ns/10ps

module axi_mem_model (
	input  logic        CLK,
	input  logic        rst_n,
	input  logic [63:0] image [256],
	input  logic        ar_stall,
	input  logic        r_stall,
	input  logic [31:0] araddr,
	input  logic        arvalid,
	output logic        arready,
	output logic [63:0] rdata,
	output logic [1:0]  rresp,
	output logic        rlast,
	output logic        rvalid,
	input  logic        rready
);

	// Word indexes of accepted reads that have not been answered yet.
	logic [7:0] pending [$];
	logic [7:0] idx;

	// The address channel is held off in cycles with ar_stall.
	assign arready = ~ar_stall;
	assign rresp = 2'b00;
	assign rlast = 1'b1;

	always @(posedge CLK) begin
		if (!rst_n) begin
			pending.delete();
			rvalid <= 1'b0;
		end else begin
			if (arvalid && arready) pending.push_back(araddr[10:3]);
			// A new beat goes out once the old one is taken, unless r_stall delays it.
			if ((!rvalid || rready) && !r_stall && pending.size() > 0) begin
				idx = pending.pop_front();
				rdata <= image[idx];
				rvalid <= 1'b1;
			end else if (rready) begin
				rvalid <= 1'b0;
			end
		end
	end

endmodule

//--- bench/tb_front_end.sv
// Testbench for the instruction front end with a program image built at time zero.
// The image covers 2 KiB from FE_RESET_PC. Words outside the program hold ADDI fillers.
// Inputs change on the falling edge and the checker samples on the rising edge.
`timescale 1ns/10ps
`include "fe_macros.svh"

module tb_front_end
	import fe_pkg::*;
();

	localparam logic [63:0] BASE = `FE_RESET_PC;
	localparam logic [63:0] JALR_TARGET = BASE + 64'h200;

	logic CLK;
	logic rst_n;
	logic [31:0] il1_araddr;
	logic [7:0] il1_arlen;
	logic [1:0] il1_arburst, il1_rresp;
	logic il1_arvalid, il1_arready, il1_rlast, il1_rvalid, il1_rready;
	logic [63:0] il1_rdata;
	logic privileged_valid, bru_res_valid, bru_taken_branch, jalr_valid;
	logic [63:0] privileged_pc, bru_target, jalr_pc;
	logic instr_fifo_reject = 1'b0;
	logic ar_stall = 1'b0;
	logic r_stall = 1'b0;
	logic instr_fifo_push, flush;
	micro_instr_t decode_micro_instr;
	logic [63:0] image [256];
	logic rand_on, class_check;
	int seed = 32'hab7c_72f8;
	int errors = 0;
	int checks = 0;

	// State of the expected push stream, owned by the checker.
	int n_pushes;
	logic [63:0] exp_pc;
	logic jalr_pending, held;
	micro_instr_t held_mi;
	logic [15:0] seen;

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	front_end dut_i (.*);

	axi_mem_model mem_i (
		.CLK(CLK), .rst_n(rst_n), .image(image), .ar_stall(ar_stall), .r_stall(r_stall),
		.araddr(il1_araddr), .arvalid(il1_arvalid), .arready(il1_arready),
		.rdata(il1_rdata), .rresp(il1_rresp), .rlast(il1_rlast),
		.rvalid(il1_rvalid), .rready(il1_rready)
	);

	// An ADDI whose immediate and registers depend on the whole address.
	function automatic logic [31:0] fill_instr(input logic [31:0] a);
		return {a[11:0] ^ a[31:20], a[19:15], 3'b000, a[6:2] ^ {2'b00, a[14:12]}, 7'h13};
	endfunction

	function automatic logic [31:0] image_instr(input logic [63:0] addr);
		logic [63:0] w;
		w = image[addr[10:3]];
		return addr[2] ? w[63:32] : w[31:0];
	endfunction

	task automatic place(input logic [63:0] addr, input logic [31:0] ins);
		if (addr[2]) image[addr[10:3]][63:32] = ins;
		else image[addr[10:3]][31:0] = ins;
	endtask

	// Expected micro-instruction, from the RV64I base encoding rules.
	function automatic micro_instr_t ref_decode(input logic [63:0] addr, input logic [31:0] ins);
		micro_instr_t m;
		m.pc = addr;
		m.instr = ins;
		m.rd = ins[11:7];
		m.rs1 = ins[19:15];
		m.rs2 = ins[24:20];
		case (ins[6:0])
			7'h33, 7'h3b: m.op = op_alu;
			7'h13, 7'h1b: m.op = op_alu_imm;
			7'h03: m.op = op_load;
			7'h23: m.op = op_store;
			7'h63: m.op = op_branch;
			7'h6f: m.op = op_jal;
			7'h67: m.op = op_jalr;
			7'h37: m.op = op_lui;
			7'h17: m.op = op_auipc;
			// Fences are grouped with the system class.
			7'h73, 7'h0f: m.op = op_system;
			default: m.op = op_illegal;
		endcase
		case (m.op)
			op_alu_imm, op_load, op_jalr, op_system: m.imm = 64'(signed'(ins[31:20]));
			op_store: m.imm = 64'(signed'({ins[31:25], ins[11:7]}));
			op_branch: m.imm = 64'(signed'({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}));
			op_lui, op_auipc: m.imm = 64'(signed'({ins[31:12], 12'h000}));
			op_jal: m.imm = 64'(signed'({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0}));
			default: m.imm = 64'd0;
		endcase
		return m;
	endfunction

	task automatic compare_values(input string what, input logic [191:0] got,
		input logic [191:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: %s mismatch, got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic abort(input string why);
		$display("%s", why);
		$display("Testbench failed");
		$finish;
	endtask

	task automatic wait_pushes(input int n);
		int target;
		int cycles;
		target = n_pushes + n;
		cycles = 0;
		while (n_pushes < target) begin
			@(negedge CLK);
			cycles++;
			if (cycles > 2000) abort($sformatf("Timed out waiting for %0d pushes.", n));
		end
	endtask

	task automatic wait_jalr_push();
		int cycles;
		cycles = 0;
		while (!jalr_pending) begin
			@(negedge CLK);
			cycles++;
			if (cycles > 500) abort("Timed out waiting for the JALR to be pushed.");
		end
	endtask

	// Drives one cycle of back-end redirect inputs.
	task automatic pulse_redirect(input logic pv, input logic [63:0] ppc, input logic bv,
		input logic bt, input logic [63:0] bpc);
		@(negedge CLK);
		privileged_valid = pv;
		privileged_pc = ppc;
		bru_res_valid = bv;
		bru_taken_branch = bt;
		bru_target = bpc;
		@(negedge CLK);
		privileged_valid = 1'b0;
		bru_res_valid = 1'b0;
		bru_taken_branch = 1'b0;
	endtask

	task automatic report(input string name);
		$display("test %s done: %0d pushes, %0d errors so far", name, n_pushes, errors);
	endtask

	task automatic build_image();
		logic [31:0] cls [13];
		logic [63:0] a;
		// One instruction of each class, then two illegal opcodes.
		cls = '{32'h00b5_0533, 32'h40b5_053b, 32'hfff5_0513, 32'h8005_051b,
			32'hff85_3503, 32'hfeb5_3c23, 32'hfe05_0ee3, 32'h8000_05b7,
			32'hffff_f517, 32'h0000_0073, 32'h0ff0_000f, 32'h0000_0000, 32'hffff_ffff};
		for (int i = 0; i < 512; i++) begin
			a = BASE + 64'(4 * i);
			place(a, fill_instr(a[31:0]));
		end
		for (int i = 0; i < 13; i++) begin
			place(BASE + 64'(4 * i), cls[i]);
			place(BASE + 64'h604 + 64'(4 * i), cls[i]);
		end
		// jal ra, +0xc4 lands in the upper half of the word at BASE+0x100.
		place(BASE + 64'h40, 32'h0c40_00ef);
		// jalr x0, 0(ra) after five fillers.
		place(BASE + 64'h118, 32'h0000_8067);
	endtask

	// Random memory delays always, random reject only while rand_on is set.
	always @(negedge CLK) begin
		logic [31:0] r;
		r = $random(seed);
		ar_stall = r[0] & r[1];
		r_stall = r[4];
		instr_fifo_reject = rand_on & (r[3:2] == 2'b00);
	end

	// Checks flush every cycle and every push that the back end accepts.
	always @(posedge CLK) begin
		micro_instr_t exp_mi;
		if (!rst_n) begin
			exp_pc = BASE;
			n_pushes = 0;
			jalr_pending = 1'b0;
			held = 1'b0;
			seen = '0;
		end else begin
			compare_values("flush", 192'(flush),
				192'(privileged_valid | (bru_res_valid & bru_taken_branch)));
			// Every read is one aligned beat of an INCR burst.
			if (il1_arvalid && il1_arready) begin
				compare_values("read address channel",
					192'({il1_arlen, il1_arburst, il1_araddr[2:0]}), 192'({8'd0, 2'b01, 3'b000}));
			end
			if (held) begin
				compare_values("push under reject", 192'(instr_fifo_push), 192'(1));
				compare_values("micro-instruction under reject", 192'(decode_micro_instr),
					192'(held_mi));
			end
			if (jalr_valid) jalr_pending = 1'b0;
			if (instr_fifo_push && !instr_fifo_reject) begin
				compare_values("push during JALR stall", 192'(jalr_pending), 192'(0));
				exp_mi = ref_decode(exp_pc, image_instr(exp_pc));
				compare_values($sformatf("micro-instruction at %h", exp_pc),
					192'(decode_micro_instr), 192'(exp_mi));
				seen[decode_micro_instr.op] = 1'b1;
				n_pushes++;
				// Branches are predicted not taken and fall through.
				if (exp_mi.op == op_jal) begin
					exp_pc = exp_pc + exp_mi.imm;
				end else if (exp_mi.op == op_jalr) begin
					exp_pc = JALR_TARGET;
					jalr_pending = 1'b1;
				end else begin
					exp_pc = exp_pc + 64'd4;
				end
			end
			// A flush drops a rejected push, so it need not hold.
			held = instr_fifo_push & instr_fifo_reject & ~flush;
			held_mi = decode_micro_instr;
			if (privileged_valid) exp_pc = privileged_pc;
			else if (bru_res_valid && bru_taken_branch) exp_pc = bru_target;
			if (class_check) compare_values("opcode classes pushed", 192'(seen), 192'(16'h07ff));
		end
	end

	initial begin
		rst_n = 1'b0;
		privileged_valid = 1'b0;
		privileged_pc = '0;
		bru_res_valid = 1'b0;
		bru_taken_branch = 1'b0;
		bru_target = '0;
		jalr_valid = 1'b0;
		jalr_pc = '0;
		rand_on = 1'b0;
		class_check = 1'b0;
		build_image();
		repeat (4) @(negedge CLK);
		rst_n = 1'b1;
		// Nothing is requested, taken or pushed straight out of reset.
		compare_values("outputs after reset",
			192'({il1_arvalid, il1_rready, instr_fifo_push, flush}), 192'(0));
		wait_pushes(16);
		report("straight-line");
		// The JAL and the five fillers from its target.
		wait_pushes(6);
		report("jal");
		wait_jalr_push();
		repeat (6) @(negedge CLK);
		jalr_valid = 1'b1;
		jalr_pc = JALR_TARGET;
		@(negedge CLK);
		jalr_valid = 1'b0;
		wait_pushes(8);
		report("jalr");
		// A resolved branch that was not taken must not flush.
		pulse_redirect(1'b0, 64'h0, 1'b1, 1'b0, BASE + 64'h700);
		wait_pushes(3);
		pulse_redirect(1'b0, 64'h0, 1'b1, 1'b1, BASE + 64'h30c);
		wait_pushes(6);
		pulse_redirect(1'b1, BASE + 64'h484, 1'b1, 1'b1, BASE + 64'h380);
		wait_pushes(6);
		report("redirects");
		rand_on <= 1'b1;
		wait_pushes(40);
		pulse_redirect(1'b0, 64'h0, 1'b1, 1'b1, BASE + 64'h50c);
		wait_pushes(40);
		rand_on <= 1'b0;
		report("random back-pressure");
		pulse_redirect(1'b1, BASE + 64'h604, 1'b0, 1'b0, 64'h0);
		wait_pushes(13);
		@(negedge CLK);
		class_check = 1'b1;
		@(negedge CLK);
		class_check = 1'b0;
		report("opcode classes");
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) $display("Testbench passed");
		else $display("Testbench failed");
		$finish;
	end

endmodule

//--- hw/decoder.sv
// Decodes base-ISA instructions into micro-instructions for the back end.
// The output register holds its value while instr_fifo_reject is high.
// Unknown opcodes are passed on as op_illegal, with no trap raised here.
`timescale 1ns/10ps

module decoder
	import fe_pkg::*;
(
	input  logic         CLK,
	input  logic         rst_n,
	input  logic         flush,
	input  logic         iq_valid,
	output logic         iq_ready,
	input  iq_entry_t    iq,
	input  logic         instr_fifo_reject,
	output logic         instr_fifo_push,
	output micro_instr_t decode_micro_instr
);

	logic [31:0] ins;
	logic [63:0] imm_i;
	logic [63:0] imm_s;
	logic [63:0] imm_b;
	logic [63:0] imm_u;
	logic [63:0] imm_j;
	micro_instr_t dec;

	assign ins = iq.instr;

	// All immediates are sign-extended from bit 31.
	assign imm_i = {{52{ins[31]}}, ins[31:20]};
	assign imm_s = {{52{ins[31]}}, ins[31:25], ins[11:7]};
	assign imm_b = {{52{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
	assign imm_u = {{32{ins[31]}}, ins[31:12], 12'b0};
	assign imm_j = {{44{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};

	always_comb begin
		dec.pc = iq.pc;
		dec.instr = ins;
		// Register fields are taken as they stand, whatever the format.
		dec.rd = ins[11:7];
		dec.rs1 = ins[19:15];
		dec.rs2 = ins[24:20];
		dec.imm = '0;
		case (ins[6:0])
			opc_op, opc_op_32: dec.op = op_alu;
			opc_op_imm, opc_op_imm_32: begin
				dec.op = op_alu_imm;
				dec.imm = imm_i;
			end
			opc_load: begin
				dec.op = op_load;
				dec.imm = imm_i;
			end
			opc_store: begin
				dec.op = op_store;
				dec.imm = imm_s;
			end
			opc_branch: begin
				dec.op = op_branch;
				dec.imm = imm_b;
			end
			opc_jal: begin
				dec.op = op_jal;
				dec.imm = imm_j;
			end
			opc_jalr: begin
				dec.op = op_jalr;
				dec.imm = imm_i;
			end
			opc_lui: begin
				dec.op = op_lui;
				dec.imm = imm_u;
			end
			opc_auipc: begin
				dec.op = op_auipc;
				dec.imm = imm_u;
			end
			// Fences go with system instructions and are ordered by the back end.
			opc_system, opc_misc_mem: begin
				dec.op = op_system;
				dec.imm = imm_i;
			end
			default: dec.op = op_illegal;
		endcase
	end

	// The register is free when empty or when its push is taken this cycle.
	assign iq_ready = (~instr_fifo_push | ~instr_fifo_reject) & ~flush;

	always_ff @(posedge CLK) begin
		if (!rst_n || flush) begin
			instr_fifo_push <= 1'b0;
		end else if (iq_ready) begin
			instr_fifo_push <= iq_valid;
		end
	end

	always_ff @(posedge CLK) begin
		if (iq_valid && iq_ready) decode_micro_instr <= dec;
	end

endmodule

//--- hw/fe_fifo.sv
// Synchronous FIFO with a payload of any type.
// No bypass. A write becomes visible at the head one cycle later.
// clear empties the FIFO in one cycle and wins over a write in that cycle.
`timescale 1ns/10ps

module fe_fifo #(
	parameter type T     = logic,
	parameter int  DEPTH = 2
) (
	input  logic CLK,
	input  logic rst_n,
	input  logic clear,
	input  logic in_valid,
	output logic in_ready,
	input  T     in_data,
	output logic out_valid,
	input  logic out_ready,
	output T     out_data
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	T mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic push;
	logic pop;

	// Pointers wrap explicitly, so the depth need not be a power of two.
	function automatic logic [AW-1:0] bump(input logic [AW-1:0] p);
		return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign in_ready = (count != CW'(DEPTH));
	assign out_valid = (count != '0);
	assign out_data = mem[rd_ptr];
	assign push = in_valid & in_ready;
	assign pop = out_valid & out_ready;

	always_ff @(posedge CLK) begin
		if (!rst_n || clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) wr_ptr <= bump(wr_ptr);
			if (pop) rd_ptr <= bump(rd_ptr);
			count <= count + CW'(push) - CW'(pop);
		end
	end

	always_ff @(posedge CLK) begin
		if (push) mem[wr_ptr] <= in_data;
	end

endmodule

//--- hw/fe_macros.svh
// Widths, depths and reset PC of the instruction front end.
// FE_IQ_DEPTH and FE_FQ_DEPTH may be any value of 1 or more.
// The read address bus is 32 bits, so FE_RESET_PC must stay below 4 GiB.
`ifndef FE_MACROS_SVH
`define FE_MACROS_SVH

// A PC and a fetched memory word are both 64 bits wide.
`define FE_PC_W 64
`define FE_FETCH_W 64
// Only 32-bit base instructions are handled, so two fit in each fetched word.
`define FE_INSTR_W 32

// Depth of the decode-side instruction buffer.
`define FE_IQ_DEPTH 4
// Depth of the fetch response buffer, and the limit on reads in flight.
`define FE_FQ_DEPTH 2

`define FE_RESET_PC 64'h8000_0000
`endif

//--- hw/fe_pkg.sv
// Types shared by the front end blocks and the back end interface.
// Opcode values cover the RV64I base set only, with no compressed forms.
`include "fe_macros.svh"

package fe_pkg;

	// A fetch request. The pc may point to the upper half of an aligned word.
	typedef struct packed {
		logic [`FE_PC_W-1:0] pc;
	} fetch_req_t;

	// One memory word returned by a read, tagged with the requested pc.
	typedef struct packed {
		logic [`FE_PC_W-1:0]    pc;
		logic [`FE_FETCH_W-1:0] data;
	} fetch_bundle_t;

	// One instruction waiting for decode.
	typedef struct packed {
		logic [`FE_PC_W-1:0]    pc;
		logic [`FE_INSTR_W-1:0] instr;
	} iq_entry_t;

	typedef struct packed {
		logic                valid;
		logic [`FE_PC_W-1:0] pc;
	} redirect_t;

	typedef enum logic [3:0] {
		op_alu, op_alu_imm, op_load, op_store, op_branch, op_jal,
		op_jalr, op_lui, op_auipc, op_system, op_illegal
	} op_class_e;

	typedef struct packed {
		logic [`FE_PC_W-1:0]    pc;
		logic [`FE_INSTR_W-1:0] instr;
		op_class_e              op;
		logic [4:0]             rd;
		logic [4:0]             rs1;
		logic [4:0]             rs2;
		logic [63:0]            imm;
	} micro_instr_t;

	// Major opcodes, bits 6 to 0 of an instruction.
	localparam logic [6:0] opc_op = 7'b0110011, opc_op_32 = 7'b0111011;
	localparam logic [6:0] opc_op_imm = 7'b0010011, opc_op_imm_32 = 7'b0011011;
	localparam logic [6:0] opc_load = 7'b0000011, opc_store = 7'b0100011;
	localparam logic [6:0] opc_branch = 7'b1100011, opc_jal = 7'b1101111;
	localparam logic [6:0] opc_jalr = 7'b1100111, opc_lui = 7'b0110111;
	localparam logic [6:0] opc_auipc = 7'b0010111, opc_system = 7'b1110011;
	localparam logic [6:0] opc_misc_mem = 7'b0001111;

endpackage

//--- hw/fetch_unit.sv
// AXI read master of the front end. Every read is a single aligned 8-byte beat.
// Read error responses are not reported. The data is passed on as it is.
// At most FE_FQ_DEPTH reads are in flight, and responses must come back in order.
`timescale 1ns/10ps
`include "fe_macros.svh"

module fetch_unit
	import fe_pkg::*;
(
	input  logic                   CLK,
	input  logic                   rst_n,
	input  logic                   redirected,
	input  logic                   req_valid,
	output logic                   req_ready,
	input  fetch_req_t             req,
	output logic [31:0]            il1_araddr,
	output logic [7:0]             il1_arlen,
	output logic [1:0]             il1_arburst,
	output logic                   il1_arvalid,
	input  logic                   il1_arready,
	input  logic [`FE_FETCH_W-1:0] il1_rdata,
	input  logic [1:0]             il1_rresp,
	input  logic                   il1_rlast,
	input  logic                   il1_rvalid,
	output logic                   il1_rready,
	output logic                   bundle_valid,
	input  logic                   bundle_ready,
	output fetch_bundle_t          bundle
);

	localparam int CW = $clog2(`FE_FQ_DEPTH + 1);

	logic [CW-1:0] count;
	logic [CW-1:0] count_nxt;
	logic [CW-1:0] discard;
	logic req_hs;
	logic r_done;
	logic tag_in_ready;
	logic tag_valid;
	logic buf_in_ready;
	fetch_req_t tag;
	fetch_bundle_t resp;

	assign il1_arlen = 8'd0;
	assign il1_arburst = 2'b01;

	// A new address can be taken while the previous one is being accepted.
	assign req_hs = req_valid & req_ready;
	assign req_ready = (~il1_arvalid | il1_arready) & (count < CW'(`FE_FQ_DEPTH))
		& tag_in_ready;

	// Stale beats are always taken. Live ones wait for room in the buffer.
	assign il1_rready = (count != '0) & ((discard != '0) | buf_in_ready);
	assign r_done = il1_rvalid & il1_rready & il1_rlast;
	assign count_nxt = count + CW'(req_hs) - CW'(r_done);

	assign resp.pc = tag.pc;
	assign resp.data = il1_rdata;

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			count <= '0;
			discard <= '0;
			il1_arvalid <= 1'b0;
		end else begin
			count <= count_nxt;
			// Every read still owed after a redirect belongs to the old path.
			if (redirected) discard <= count_nxt;
			else if (r_done && discard != '0) discard <= discard - 1'b1;
			if (req_hs) il1_arvalid <= 1'b1;
			else if (il1_arready) il1_arvalid <= 1'b0;
		end
	end

	always_ff @(posedge CLK) begin
		if (req_hs) il1_araddr <= {req.pc[31:3], 3'b000};
	end

	// The requested pc of each live read, in issue order.
	fe_fifo #(.T(fetch_req_t), .DEPTH(`FE_FQ_DEPTH)) tag_fifo_i (
		.CLK(CLK), .rst_n(rst_n), .clear(redirected),
		.in_valid(req_hs), .in_ready(tag_in_ready), .in_data(req),
		.out_valid(tag_valid), .out_ready(r_done & (discard == '0)), .out_data(tag)
	);

	fe_fifo #(.T(fetch_bundle_t), .DEPTH(`FE_FQ_DEPTH)) resp_fifo_i (
		.CLK(CLK), .rst_n(rst_n), .clear(redirected),
		.in_valid(r_done & (discard == '0) & ~redirected & tag_valid),
		.in_ready(buf_in_ready), .in_data(resp),
		.out_valid(bundle_valid), .out_ready(bundle_ready), .out_data(bundle)
	);

endmodule

//--- hw/front_end.sv
// Top level of the instruction front end.
// flush is raised by a privileged redirect or a taken-branch misprediction.
// jalr_valid must come only after the JALR has been pushed to the back end.
`timescale 1ns/10ps
`include "fe_macros.svh"

module front_end
	import fe_pkg::*;
(
	input  logic                   CLK,
	input  logic                   rst_n,
	output logic [31:0]            il1_araddr,
	output logic [7:0]             il1_arlen,
	output logic [1:0]             il1_arburst,
	output logic                   il1_arvalid,
	input  logic                   il1_arready,
	input  logic [`FE_FETCH_W-1:0] il1_rdata,
	input  logic [1:0]             il1_rresp,
	input  logic                   il1_rlast,
	input  logic                   il1_rvalid,
	output logic                   il1_rready,
	input  logic                   privileged_valid,
	input  logic [`FE_PC_W-1:0]    privileged_pc,
	input  logic                   bru_res_valid,
	input  logic                   bru_taken_branch,
	input  logic [`FE_PC_W-1:0]    bru_target,
	input  logic                   jalr_valid,
	input  logic [`FE_PC_W-1:0]    jalr_pc,
	input  logic                   instr_fifo_reject,
	output logic                   instr_fifo_push,
	output micro_instr_t           decode_micro_instr,
	output logic                   flush
);

	redirect_t privileged, mispredict, jump, iq_jal, iq_jalr;
	fetch_req_t req;
	fetch_bundle_t bundle;
	iq_entry_t iq;
	logic redirected, req_valid, req_ready;
	logic bundle_valid, bundle_ready, iq_valid, iq_ready;

	// Branches are predicted not taken, so only a taken one is a misprediction.
	assign privileged = '{valid: privileged_valid, pc: privileged_pc};
	assign mispredict = '{valid: bru_res_valid & bru_taken_branch, pc: bru_target};
	assign flush = privileged.valid | mispredict.valid;

	// JAL and a resolved JALR share the lowest priority. They never coincide,
	// because the queue takes nothing while a JALR is pending.
	assign jump = iq_jal.valid ? iq_jal : iq_jalr;

	pc_gen pc_gen_i (
		.CLK(CLK), .rst_n(rst_n), .privileged(privileged), .mispredict(mispredict),
		.jal_redirect(jump), .redirected(redirected),
		.req_valid(req_valid), .req(req), .req_ready(req_ready)
	);

	fetch_unit fetch_unit_i (
		.CLK(CLK), .rst_n(rst_n), .redirected(redirected),
		.req_valid(req_valid), .req_ready(req_ready), .req(req),
		.il1_araddr(il1_araddr), .il1_arlen(il1_arlen), .il1_arburst(il1_arburst),
		.il1_arvalid(il1_arvalid), .il1_arready(il1_arready), .il1_rdata(il1_rdata),
		.il1_rresp(il1_rresp), .il1_rlast(il1_rlast), .il1_rvalid(il1_rvalid),
		.il1_rready(il1_rready),
		.bundle_valid(bundle_valid), .bundle_ready(bundle_ready), .bundle(bundle)
	);

	// The queue keeps the instructions older than its own jumps, so only
	// a flush clears it.
	instr_queue instr_queue_i (
		.CLK(CLK), .rst_n(rst_n), .redirected(flush),
		.bundle_valid(bundle_valid), .bundle_ready(bundle_ready), .bundle(bundle),
		.jalr_valid(jalr_valid), .jalr_pc(jalr_pc),
		.jal_redirect(iq_jal), .jalr_redirect(iq_jalr),
		.iq_valid(iq_valid), .iq_ready(iq_ready), .iq(iq)
	);

	decoder decoder_i (
		.CLK(CLK), .rst_n(rst_n), .flush(flush),
		.iq_valid(iq_valid), .iq_ready(iq_ready), .iq(iq),
		.instr_fifo_reject(instr_fifo_reject), .instr_fifo_push(instr_fifo_push),
		.decode_micro_instr(decode_micro_instr)
	);

endmodule

//--- hw/instr_queue.sv
// Splits fetched words into 32-bit instructions and buffers them for decode.
// Detects JAL and JALR itself. Conditional branches are predicted not taken.
// redirected clears the buffer, and must only be raised by a flush.
`timescale 1ns/10ps
`include "fe_macros.svh"

module instr_queue
	import fe_pkg::*;
(
	input  logic                CLK,
	input  logic                rst_n,
	input  logic                redirected,
	input  logic                bundle_valid,
	output logic                bundle_ready,
	input  fetch_bundle_t       bundle,
	input  logic                jalr_valid,
	input  logic [`FE_PC_W-1:0] jalr_pc,
	output redirect_t           jal_redirect,
	output redirect_t           jalr_redirect,
	output logic                iq_valid,
	input  logic                iq_ready,
	output iq_entry_t           iq
);

	logic lo_taken;
	logic wait_jalr;
	logic cur_hi;
	logic write;
	logic in_ready;
	logic is_jal;
	logic is_jalr;
	logic [`FE_INSTR_W-1:0] instr;
	logic [63:0] j_imm;
	iq_entry_t entry;

	// The low half is skipped when the bundle starts at an offset of 4.
	assign cur_hi = bundle.pc[2] | lo_taken;
	assign instr = cur_hi ? bundle.data[63:32] : bundle.data[31:0];
	assign entry.pc = {bundle.pc[`FE_PC_W-1:3], cur_hi, 2'b00};
	assign entry.instr = instr;

	assign is_jal = (instr[6:0] == opc_jal);
	assign is_jalr = (instr[6:0] == opc_jalr);

	// One instruction per cycle, none while a JALR target is pending.
	assign write = bundle_valid & in_ready & ~wait_jalr & ~redirected;

	// The bundle is done after its high half, or early after any jump
	// since the rest of it is off the path.
	assign bundle_ready = write & (cur_hi | is_jal | is_jalr);

	assign j_imm = {{44{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

	// The JAL itself enters the buffer in the same cycle as its redirect.
	assign jal_redirect.valid = write & is_jal;
	assign jal_redirect.pc = entry.pc + j_imm;

	assign jalr_redirect.valid = wait_jalr & jalr_valid;
	assign jalr_redirect.pc = jalr_pc;

	always_ff @(posedge CLK) begin
		if (!rst_n || redirected) begin
			lo_taken <= 1'b0;
			wait_jalr <= 1'b0;
		end else begin
			if (bundle_ready) lo_taken <= 1'b0;
			else if (write) lo_taken <= 1'b1;
			// Held until the back end has computed the target.
			if (write && is_jalr) wait_jalr <= 1'b1;
			else if (jalr_valid) wait_jalr <= 1'b0;
		end
	end

	fe_fifo #(.T(iq_entry_t), .DEPTH(`FE_IQ_DEPTH)) iq_fifo_i (
		.CLK(CLK), .rst_n(rst_n), .clear(redirected),
		.in_valid(write), .in_ready(in_ready), .in_data(entry),
		.out_valid(iq_valid), .out_ready(iq_ready), .out_data(iq)
	);

endmodule

//--- hw/pc_gen.sv
// Fetch PC generator and redirect arbiter of the front end.
// Redirect inputs are expected to be single-cycle pulses.
// No request is offered in a cycle with a redirect.
`timescale 1ns/10ps
`include "fe_macros.svh"

module pc_gen
	import fe_pkg::*;
(
	input  logic       CLK,
	input  logic       rst_n,
	input  redirect_t  privileged,
	input  redirect_t  mispredict,
	input  redirect_t  jal_redirect,
	output logic       redirected,
	output logic       req_valid,
	output fetch_req_t req,
	input  logic       req_ready
);

	logic [`FE_PC_W-1:0] fetch_pc;
	redirect_t sel;

	// Traps and returns win over a misprediction, which wins over the
	// front end's own jump redirect.
	always_comb begin
		if (privileged.valid) begin
			sel = privileged;
		end else if (mispredict.valid) begin
			sel = mispredict;
		end else begin
			sel = jal_redirect;
		end
	end

	// The datapath drops everything younger than the redirect in this cycle.
	assign redirected = sel.valid;

	// A request made now would use the old PC, so it is held back.
	assign req_valid = ~redirected;
	assign req.pc = fetch_pc;

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			fetch_pc <= `FE_RESET_PC;
		end else if (redirected) begin
			fetch_pc <= sel.pc;
		end else if (req_valid && req_ready) begin
			// Move on to the next aligned word, whatever offset this one had.
			fetch_pc <= {fetch_pc[`FE_PC_W-1:3] + 1'b1, 3'b000};
		end
	end

endmodule

//--- tb.f
+incdir+hw
hw/fe_pkg.sv
hw/fe_fifo.sv
hw/pc_gen.sv
hw/fetch_unit.sv
hw/instr_queue.sv
hw/decoder.sv
hw/front_end.sv
bench/axi_mem_model.sv
bench/tb_front_end.sv
